// File: source/pong_consts.svh
// game geometry and timing for a 320x240 grid with 4x4 sprites; values are not range checked
`ifndef PONG_CONSTS_SVH
`define PONG_CONSTS_SVH

// screen size in pixels
`define PONG_SCREEN_W 320
`define PONG_SCREEN_H 240

`define PONG_SPRITE 4 // edge of every sprite, ball and paddles alike

// ball start, roughly centred
`define PONG_BALL_X0 156
`define PONG_BALL_Y0 116
`define PONG_BALL_X_MAX 316 // screen width minus sprite
`define PONG_BALL_Y_MAX 236

// paddles sit in fixed columns
`define PONG_PADDLE_X_L 2
`define PONG_PADDLE_X_R 314
`define PONG_PADDLE_Y0 116
`define PONG_PADDLE_Y_MAX 216 // lowest row a paddle may reach

`define PONG_BALL_SPEED 2 // ball moves this far on each axis per round
`define PONG_WIN_SCORE 11

// cycles between round starts
// a round takes 102 cycles anyway, so small values just mean back to back rounds
`define PONG_FRAME_CYCLES 8

`endif

// File: source/pong_pkg.sv
// types shared by the pong core; x is 9 bits and y 8 bits, enough for 320x240 only
`default_nettype none

package pong_pkg;

	// pixel position on screen
	typedef struct packed
	{
		logic [8:0] x; // column 0..319
		logic [7:0] y; // row 0..239
	} coord_t;

	// one player's buttons
	typedef struct packed
	{
		logic up;    // direction, low means down
		logic go;    // move at all
		logic speed; // double step
	} paddle_cmd_t;

	// write port towards the frame buffer
	typedef struct packed
	{
		logic        plot;   // write strobe
		logic [8:0]  x;
		logic [7:0]  y;
		logic [23:0] colour; // 8 bits per channel
	} pixel_t;

	// which object the round strobes address
	typedef enum logic [1:0]
	{
		SEL_BALL  = 2'd0,
		SEL_PAD_L = 2'd1,
		SEL_PAD_R = 2'd2,
		SEL_NONE  = 2'd3
	} obj_sel_t;

	// sequencer strobes
	typedef struct packed
	{
		logic     erase;   // level, 16 cycles
		logic     check;   // pulse
		logic     move;    // pulse
		logic     draw;    // level, 16 cycles
		logic     restart; // pulse, all objects back to start
		obj_sel_t sel;
	} step_t;

endpackage

`default_nettype wire

// File: source/round_sequencer.sv
// game FSM; rounds last 102 cycles, no back-pressure, scores stop at PONG_WIN_SCORE
`timescale 1ns/100ps
`default_nettype none
`include "pong_consts.svh"

module round_sequencer
	import pong_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       serve_i,     // level or pulse, sampled in SERVE
	input  logic       new_game_i,
	input  logic       point_l_i,   // from the ball check cycle
	input  logic       point_r_i,
	output step_t      step_o,
	output logic [3:0] pix_cnt_o,   // pixel index inside the sprite
	output logic [3:0] score_l_o,
	output logic [3:0] score_r_o,
	output logic       game_over_o
);
	localparam int FRAME_W = 24;
	localparam logic [FRAME_W-1:0] FRAME_RELOAD = FRAME_W'(`PONG_FRAME_CYCLES - 1);
	localparam logic [3:0] WIN = 4'(`PONG_WIN_SCORE);

	// state encoding
	localparam logic [3:0] ST_START    = 4'd0;
	localparam logic [3:0] ST_WAIT     = 4'd1;
	localparam logic [3:0] ST_ERASE    = 4'd2;
	localparam logic [3:0] ST_CHECK    = 4'd3;
	localparam logic [3:0] ST_MOVE     = 4'd4;
	localparam logic [3:0] ST_DRAW     = 4'd5;
	localparam logic [3:0] ST_CLEAR    = 4'd6;
	localparam logic [3:0] ST_SERVE    = 4'd7;
	localparam logic [3:0] ST_GAMEOVER = 4'd8;

	logic [3:0]         state;
	obj_sel_t           sel;       // object in work
	obj_sel_t           sel_next;
	logic [FRAME_W-1:0] frame_cnt; // counts down to the next round
	logic [3:0]         pix_cnt;
	logic               pix_last;  // 16th pixel of a burst
	logic               win;

	assign pix_last    = (pix_cnt == 4'd15);
	assign win         = (score_l_o >= WIN) || (score_r_o >= WIN);
	assign sel_next    = obj_sel_t'(sel + 2'd1); // ball, left, right order
	assign pix_cnt_o   = pix_cnt;
	assign game_over_o = (state == ST_GAMEOVER);

	always_comb
	begin
		step_o.erase   = (state == ST_ERASE) || (state == ST_CLEAR);
		step_o.check   = (state == ST_CHECK);
		step_o.move    = (state == ST_MOVE);
		step_o.draw    = (state == ST_DRAW);
		// new game, or end of a clear pass without a winner
		step_o.restart = ((state == ST_START || state == ST_GAMEOVER) && new_game_i)
			|| (state == ST_CLEAR && pix_last && sel == SEL_PAD_R && !win);
		step_o.sel     = sel;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= ST_START;
			sel       <= SEL_NONE;
			frame_cnt <= '0;
			pix_cnt   <= 4'd0;
			score_l_o <= 4'd0;
			score_r_o <= 4'd0;
		end
		else
		begin
			if (frame_cnt != '0)
				frame_cnt <= frame_cnt - 1'b1; // free running tick
			case (state)
				ST_START, ST_GAMEOVER:
					if (new_game_i)
					begin
						score_l_o <= 4'd0;
						score_r_o <= 4'd0;
						state     <= ST_WAIT;
					end
				ST_WAIT:
					if (frame_cnt == '0) // frame expired, start a round
					begin
						frame_cnt <= FRAME_RELOAD;
						sel       <= SEL_BALL;
						state     <= ST_ERASE;
					end
				ST_ERASE:
				begin
					pix_cnt <= pix_cnt + 4'd1; // wraps back to 0 after the burst
					if (pix_last)
						state <= ST_CHECK;
				end
				ST_CHECK:
					if (point_l_i || point_r_i)
					begin
						if (point_l_i)
							score_l_o <= score_l_o + 4'd1;
						if (point_r_i)
							score_r_o <= score_r_o + 4'd1;
						sel   <= SEL_BALL; // clear pass erases everything
						state <= ST_CLEAR;
					end
					else
						state <= ST_MOVE;
				ST_MOVE:
					state <= ST_DRAW;
				ST_DRAW:
				begin
					pix_cnt <= pix_cnt + 4'd1;
					if (pix_last)
					begin
						if (sel == SEL_PAD_R) // round done
						begin
							sel   <= SEL_NONE;
							state <= ST_WAIT;
						end
						else
						begin
							sel   <= sel_next;
							state <= ST_ERASE;
						end
					end
				end
				ST_CLEAR:
				begin
					pix_cnt <= pix_cnt + 4'd1;
					if (pix_last)
					begin
						if (sel == SEL_PAD_R)
						begin
							sel   <= SEL_NONE;
							state <= win ? ST_GAMEOVER : ST_SERVE;
						end
						else
							sel <= sel_next;
					end
				end
				ST_SERVE:
					if (serve_i)
						state <= ST_WAIT;
				default:
					state <= ST_START;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/ball_engine.sv
// ball physics; speed is fixed per axis, state is only valid after the first restart strobe
`timescale 1ns/100ps
`default_nettype none
`include "pong_consts.svh"

module ball_engine
	import pong_pkg::*;
(
	input  logic         clk,
	input  step_t        step_i,
	input  coord_t [1:0] paddle_pos_i, // 0 left, 1 right
	output coord_t       ball_o,
	output logic         point_l_o,    // left player scores
	output logic         point_r_o
);
	localparam logic [8:0] SPEED_X = 9'(`PONG_BALL_SPEED);
	localparam logic [7:0] SPEED_Y = 8'(`PONG_BALL_SPEED);
	localparam logic [8:0] X_MAX   = 9'(`PONG_BALL_X_MAX);
	localparam logic [7:0] Y_MAX   = 8'(`PONG_BALL_Y_MAX);
	localparam logic [8:0] FACE_L  = 9'(`PONG_PADDLE_X_L + `PONG_SPRITE); // 6
	localparam logic [8:0] FACE_R  = 9'(`PONG_PADDLE_X_R - `PONG_SPRITE); // 310

	logic       left_q; // heading left
	logic       up_q;   // heading up
	logic       is_ball;
	logic       near_l; // rows overlap left paddle
	logic       near_r;
	logic       wall_hit;
	logic [8:0] x_next;
	logic [7:0] y_next;

	// rows overlap when they are at most sprite-1 apart
	function automatic logic rows_overlap(input logic [7:0] a, input logic [7:0] b);
		logic [8:0] a_ext;
		logic [8:0] b_ext;
		a_ext = {1'b0, a};
		b_ext = {1'b0, b};
		return (a_ext <= b_ext + 9'(`PONG_SPRITE - 1)) && (b_ext <= a_ext + 9'(`PONG_SPRITE - 1));
	endfunction

	assign is_ball  = (step_i.sel == SEL_BALL);
	assign near_l   = rows_overlap(ball_o.y, paddle_pos_i[0].y);
	assign near_r   = rows_overlap(ball_o.y, paddle_pos_i[1].y);
	assign wall_hit = (up_q && ball_o.y == 8'd0) || (!up_q && ball_o.y == Y_MAX);

	// side edges, only in the ball check cycle
	assign point_r_o = is_ball && step_i.check && left_q && (ball_o.x == 9'd0);
	assign point_l_o = is_ball && step_i.check && !left_q && (ball_o.x == X_MAX);

	always_comb
	begin
		if (up_q)
			y_next = (ball_o.y < SPEED_Y) ? 8'd0 : ball_o.y - SPEED_Y;
		else
			y_next = (ball_o.y > Y_MAX - SPEED_Y) ? Y_MAX : ball_o.y + SPEED_Y;
		if (left_q)
		begin
			if (near_l && ball_o.x > FACE_L && ball_o.x < FACE_L + SPEED_X)
				x_next = FACE_L; // would cross the left face
			else if (ball_o.x < SPEED_X)
				x_next = 9'd0;
			else
				x_next = ball_o.x - SPEED_X;
		end
		else
		begin
			if (near_r && ball_o.x < FACE_R && ball_o.x + SPEED_X > FACE_R)
				x_next = FACE_R;
			else if (ball_o.x > X_MAX - SPEED_X)
				x_next = X_MAX;
			else
				x_next = ball_o.x + SPEED_X;
		end
	end

	always_ff @(posedge clk)
	begin
		if (step_i.restart)
		begin
			ball_o.x <= 9'(`PONG_BALL_X0);
			ball_o.y <= 8'(`PONG_BALL_Y0);
			left_q   <= 1'b1; // serve towards the left player, downwards
			up_q     <= 1'b0;
		end
		else if (is_ball && step_i.check)
		begin
			if (wall_hit)
				up_q <= ~up_q;
			if (left_q && ball_o.x == FACE_L && near_l)
				left_q <= 1'b0; // bounce off left paddle
			else if (!left_q && ball_o.x == FACE_R && near_r)
				left_q <= 1'b1;
		end
		else if (is_ball && step_i.move)
		begin
			ball_o.x <= x_next;
			ball_o.y <= y_next;
		end
	end

endmodule

`default_nettype wire

// File: source/paddle_unit.sv
// one paddle, vertical motion only; PADDLE_IDX 0 is left and 1 is right, no other values
`timescale 1ns/100ps
`default_nettype none
`include "pong_consts.svh"

module paddle_unit
	import pong_pkg::*;
#(
	parameter int PADDLE_IDX = 0
)
(
	input  logic        clk,
	input  step_t       step_i,
	input  paddle_cmd_t cmd_i,
	output coord_t      pos_o
);
	localparam obj_sel_t MY_SEL = (PADDLE_IDX == 0) ? SEL_PAD_L : SEL_PAD_R;
	localparam logic [8:0] X_COL = (PADDLE_IDX == 0) ? 9'(`PONG_PADDLE_X_L)
		: 9'(`PONG_PADDLE_X_R);
	localparam logic signed [9:0] Y_LIM = 10'(`PONG_PADDLE_Y_MAX);

	logic signed [2:0] dy_q;  // -2..+2 rows per round
	logic [7:0]        y_q;
	logic signed [9:0] y_sum; // unclamped next row
	logic              mine;

	assign mine  = (step_i.sel == MY_SEL);
	assign y_sum = $signed({2'b00, y_q}) + 10'(dy_q);
	assign pos_o = '{x: X_COL, y: y_q}; // column never changes

	always_ff @(posedge clk)
	begin
		if (step_i.restart)
		begin
			y_q  <= 8'(`PONG_PADDLE_Y0);
			dy_q <= 3'sd0;
		end
		else if (mine && step_i.check)
		begin
			if (!cmd_i.go)
				dy_q <= 3'sd0;           // hold still
			else if (cmd_i.up)
				dy_q <= cmd_i.speed ? -3'sd2 : -3'sd1;
			else
				dy_q <= cmd_i.speed ? 3'sd2 : 3'sd1;
		end
		else if (mine && step_i.move)
		begin
			if (y_sum < 10'sd0)
				y_q <= 8'd0;             // top clamp
			else if (y_sum > Y_LIM)
				y_q <= Y_LIM[7:0];
			else
				y_q <= y_sum[7:0];
		end
	end

endmodule

`default_nettype wire

// File: source/sprite_plotter.sv
// 4x4 sprite writer, one pixel per cycle with one cycle latency; sink must never stall
`timescale 1ns/100ps
`default_nettype none

module sprite_plotter
	import pong_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  step_t        step_i,
	input  logic [3:0]   pix_cnt_i,    // col in [1:0], row in [3:2]
	input  coord_t       ball_i,
	input  coord_t [1:0] paddle_pos_i,
	output pixel_t       pixel_o
);
	coord_t base;   // top left corner of the selected sprite
	logic   active;

	always_comb
	begin
		case (step_i.sel)
			SEL_PAD_L: base = paddle_pos_i[0];
			SEL_PAD_R: base = paddle_pos_i[1];
			default:   base = ball_i; // ball, and don't care for none
		endcase
	end

	// no writes outside erase/draw or without a target
	assign active = (step_i.erase || step_i.draw) && (step_i.sel != SEL_NONE);

	always_ff @(posedge clk)
	begin
		pixel_o.x      <= base.x + {7'd0, pix_cnt_i[1:0]};
		pixel_o.y      <= base.y + {6'd0, pix_cnt_i[3:2]};
		pixel_o.colour <= step_i.draw ? 24'hff_ffff : 24'h00_0000; // white or black
		if (reset)
			pixel_o.plot <= 1'b0;
		else
			pixel_o.plot <= active;
	end

endmodule

`default_nettype wire

// File: source/pong_top.sv
// pong core top; pixel writes go straight out, scores are binary and saturate at the win score
`timescale 1ns/100ps
`default_nettype none

module pong_top
	import pong_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  paddle_cmd_t cmd_l_i,
	input  paddle_cmd_t cmd_r_i,
	input  logic        serve_i,
	input  logic        new_game_i,
	output pixel_t      pixel_o,
	output logic [3:0]  score_l_o,
	output logic [3:0]  score_r_o,
	output logic        game_over_o
);
	step_t        step;       // strobes from the sequencer
	logic [3:0]   pix_cnt;
	logic         point_l;
	logic         point_r;
	coord_t       ball;
	coord_t [1:0] paddle_pos; // 0 left, 1 right

	round_sequencer round_sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.serve_i     (serve_i),
		.new_game_i  (new_game_i),
		.point_l_i   (point_l),
		.point_r_i   (point_r),
		.step_o      (step),
		.pix_cnt_o   (pix_cnt),
		.score_l_o   (score_l_o),
		.score_r_o   (score_r_o),
		.game_over_o (game_over_o)
	);

	ball_engine ball_engine_i (
		.clk          (clk),
		.step_i       (step),
		.paddle_pos_i (paddle_pos),
		.ball_o       (ball),
		.point_l_o    (point_l),
		.point_r_o    (point_r)
	);

	// both paddles are player driven
	for (genvar i = 0; i < 2; i++)
	begin : g_paddle
		paddle_unit #(
			.PADDLE_IDX (i)
		) paddle_unit_i (
			.clk    (clk),
			.step_i (step),
			.cmd_i  ((i == 0) ? cmd_l_i : cmd_r_i),
			.pos_o  (paddle_pos[i])
		);
	end

	sprite_plotter sprite_plotter_i (
		.clk          (clk),
		.reset        (reset),
		.step_i       (step),
		.pix_cnt_i    (pix_cnt),
		.ball_i       (ball),
		.paddle_pos_i (paddle_pos),
		.pixel_o      (pixel_o)
	);

endmodule

`default_nettype wire

// File: bench/pong_sva.sv
// assertions bound into pong_top; plot is registered, so game over is checked one cycle late
`timescale 1ns/100ps
`default_nettype none
`include "pong_consts.svh"

module pong_sva
	import pong_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input pixel_t     pixel_i,
	input logic [3:0] score_l_i,
	input logic [3:0] score_r_i,
	input logic       game_over_i
);
	// last clear pixel may still leave in the first game over cycle
	a_quiet_game_over: assert property (@(posedge clk) disable iff (reset)
		$past(game_over_i) |-> !pixel_i.plot) else $error("pixel plotted in game over");

	a_score_limit: assert property (@(posedge clk) disable iff (reset)
		score_l_i <= 4'(`PONG_WIN_SCORE) && score_r_i <= 4'(`PONG_WIN_SCORE))
		else $error("score above 11");

	a_on_screen: assert property (@(posedge clk) disable iff (reset)
		pixel_i.plot |-> (pixel_i.x < 9'(`PONG_SCREEN_W) && pixel_i.y < 8'(`PONG_SCREEN_H)))
		else $error("pixel off screen");

endmodule

bind pong_top pong_sva pong_sva_i (
	.clk         (clk),
	.reset       (reset),
	.pixel_i     (pixel_o),
	.score_l_i   (score_l_o),
	.score_r_i   (score_r_o),
	.game_over_i (game_over_o)
);

`default_nettype wire

// File: bench/pong_checker.sv
// pixel stream and score monitor; assumes bursts of 16 and erase/draw colours 0 and all ones
`timescale 1ns/100ps
`default_nettype none
`include "pong_consts.svh"

module pong_checker
	import pong_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  pixel_t       pixel_i,
	input  logic [3:0]   score_l_i,
	input  logic [3:0]   score_r_i,
	input  logic         game_over_i,
	input  logic         check_i,         // compare now
	input  int           step_i,
	input  coord_t       exp_ball_i,
	input  coord_t [1:0] exp_pad_i,
	input  logic [3:0]   exp_score_l_i,
	input  logic [3:0]   exp_score_r_i,
	input  logic         exp_game_over_i,
	output int           rounds_o,        // completed rounds including point rounds
	output int           errors_o,
	output int           steps_failed_o
);
	int          pix_n;        // pixel index in current burst
	int          slot;         // burst index within a normal round
	int          clear_n;      // bursts seen in a clear pass
	logic        clearing;
	logic        burst_bad;    // report only the first wrong pixel
	int          step_bad;     // mismatches in the current step
	coord_t      first;        // top left of burst
	logic [23:0] col;
	coord_t      last_draw[3]; // ball, left, right

	function automatic string obj_name(input int obj);
		case (obj)
			0:       return "ball";
			1:       return "left paddle";
			default: return "right paddle";
		endcase
	endfunction

	// every mismatch counts against the run and the current step
	task automatic note_error();
		errors_o = errors_o + 1;
		step_bad = step_bad + 1;
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got != want)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, want);
			note_error();
		end
	endtask

	// objects come back here after restart
	task automatic start_positions();
		last_draw[0] = '{x: 9'(`PONG_BALL_X0), y: 8'(`PONG_BALL_Y0)};
		last_draw[1] = '{x: 9'(`PONG_PADDLE_X_L), y: 8'(`PONG_PADDLE_Y0)};
		last_draw[2] = '{x: 9'(`PONG_PADDLE_X_R), y: 8'(`PONG_PADDLE_Y0)};
	endtask

	task automatic check_pixel();
		logic [8:0] want_x;
		logic [7:0] want_y;
		want_x = first.x + 9'(pix_n % 4); // row major inside the sprite
		want_y = first.y + 8'(pix_n / 4);
		if (!burst_bad && (pixel_i.x != want_x || pixel_i.y != want_y || pixel_i.colour != col))
		begin
			burst_bad = 1'b1;
			report_value("pixel_o.x", 32'(pixel_i.x), 32'(want_x));
			report_value("pixel_o.y", 32'(pixel_i.y), 32'(want_y));
			report_value("pixel_o.colour", 32'(pixel_i.colour), 32'(col));
		end
	endtask

	// erases must hit where the object was last drawn
	task automatic check_erase(input int obj);
		if (first != last_draw[obj])
		begin
			$display("FAILED pixel_o erase of %s at x %h y %h, expected x %h y %h", obj_name(obj),
				first.x, first.y, last_draw[obj].x, last_draw[obj].y);
			note_error();
		end
	endtask

	task automatic finish_burst();
		logic is_draw;
		logic want_draw;
		int   obj;
		is_draw = (col == 24'hff_ffff);
		if (col != 24'h0 && !is_draw)
		begin
			$display("FAILED pixel_o.colour: got %h, expected 000000 or ffffff", col);
			note_error();
		end
		if (clearing)
		begin
			if (is_draw)
			begin
				$display("clear pass drew the %s instead of erasing it", obj_name(clear_n));
				note_error();
			end
			else
				check_erase(clear_n);
			clear_n = clear_n + 1;
			if (clear_n == 3) // point round over and objects restart
			begin
				clearing = 1'b0;
				slot     = 0;
				rounds_o = rounds_o + 1;
				start_positions();
			end
		end
		else if (slot == 1 && !is_draw)
		begin
			clearing = 1'b1; // ball scored and the clear pass began
			check_erase(0);
			clear_n  = 1;
		end
		else
		begin
			obj       = slot / 2;
			want_draw = (slot % 2 == 1);
			if (is_draw != want_draw)
			begin
				$display("burst for the %s came in the wrong phase of the round", obj_name(obj));
				note_error();
			end
			else if (is_draw)
				last_draw[obj] = first;
			else
				check_erase(obj);
			slot = slot + 1;
			if (slot == 6)
			begin
				slot     = 0;
				rounds_o = rounds_o + 1;
			end
		end
	endtask

	task automatic compare_step();
		report_value("ball x", 32'(last_draw[0].x), 32'(exp_ball_i.x));
		report_value("ball y", 32'(last_draw[0].y), 32'(exp_ball_i.y));
		report_value("left paddle x", 32'(last_draw[1].x), 32'(exp_pad_i[0].x));
		report_value("left paddle y", 32'(last_draw[1].y), 32'(exp_pad_i[0].y));
		report_value("right paddle x", 32'(last_draw[2].x), 32'(exp_pad_i[1].x));
		report_value("right paddle y", 32'(last_draw[2].y), 32'(exp_pad_i[1].y));
		report_value("score_l_o", 32'(score_l_i), 32'(exp_score_l_i));
		report_value("score_r_o", 32'(score_r_i), 32'(exp_score_r_i));
		report_value("game_over_o", 32'(game_over_i), 32'(exp_game_over_i));
		if (step_bad == 0)
			$display("step %0d passed", step_i);
		else
		begin
			$display("step %0d failed with %0d mismatches", step_i, step_bad);
			steps_failed_o = steps_failed_o + 1;
		end
		step_bad = 0; // next step starts clean
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			pix_n          = 0;
			slot           = 0;
			clear_n        = 0;
			clearing       = 1'b0;
			burst_bad      = 1'b0;
			step_bad       = 0;
			rounds_o       = 0;
			errors_o       = 0;
			steps_failed_o = 0;
			start_positions();
		end
		else
		begin
			if (pixel_i.plot)
			begin
				if (pix_n == 0)
				begin
					first     = '{x: pixel_i.x, y: pixel_i.y};
					col       = pixel_i.colour;
					burst_bad = 1'b0;
				end
				else
					check_pixel();
				if (pix_n == 15)
				begin
					finish_burst();
					pix_n = 0;
				end
				else
					pix_n = pix_n + 1;
			end
			else if (pix_n != 0)
			begin
				$display("pixel burst broke off after %0d pixels", pix_n);
				note_error();
				pix_n = 0;
			end
			if (check_i)
				compare_step();
		end
	end

endmodule

`default_nettype wire

// File: bench/pong_tb.sv
// testbench top; runs from the project root, stim rows in bench/pong_stim.txt, hex cmd columns
`timescale 1ns/100ps
`default_nettype none
`include "pong_consts.svh"

module pong_tb
	import pong_pkg::*;
();
	// one stim row
	typedef struct packed
	{
		logic [15:0] rounds;
		logic [2:0]  cmd_l;
		logic [2:0]  cmd_r;
		logic [1:0]  pulse;   // 1 serve, 2 new game
		logic [7:0]  pad_l_y;
		logic [7:0]  pad_r_y;
		logic [8:0]  ball_x;
		logic [7:0]  ball_y;
		logic [3:0]  score_l;
		logic [3:0]  score_r;
		logic        game_over;
	} stim_t;

	logic         clk;
	logic         reset;
	paddle_cmd_t  cmd_l;
	paddle_cmd_t  cmd_r;
	logic         serve;
	logic         new_game;
	pixel_t       pixel;
	logic [3:0]   score_l;
	logic [3:0]   score_r;
	logic         game_over;
	logic         check_req;   // one cycle, checker compares
	int           step_num;
	coord_t       exp_ball;
	coord_t [1:0] exp_pad;
	logic [3:0]   exp_score_l;
	logic [3:0]   exp_score_r;
	logic         exp_game_over;
	int           rounds_done;
	int           errors;
	int           steps_failed;
	int           watchdog_cycles = 0;
	stim_t        steps[$];

	pong_top pong_top_i (
		.clk         (clk),
		.reset       (reset),
		.cmd_l_i     (cmd_l),
		.cmd_r_i     (cmd_r),
		.serve_i     (serve),
		.new_game_i  (new_game),
		.pixel_o     (pixel),
		.score_l_o   (score_l),
		.score_r_o   (score_r),
		.game_over_o (game_over)
	);

	pong_checker pong_checker_i (
		.clk             (clk),
		.reset           (reset),
		.pixel_i         (pixel),
		.score_l_i       (score_l),
		.score_r_i       (score_r),
		.game_over_i     (game_over),
		.check_i         (check_req),
		.step_i          (step_num),
		.exp_ball_i      (exp_ball),
		.exp_pad_i       (exp_pad),
		.exp_score_l_i   (exp_score_l),
		.exp_score_r_i   (exp_score_r),
		.exp_game_over_i (exp_game_over),
		.rounds_o        (rounds_done),
		.errors_o        (errors),
		.steps_failed_o  (steps_failed)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// whole file read up front so the watchdog limit is known
	task automatic load_stim(output bit ok, output int total);
		int    fd;
		int    code;
		int    n;
		string line;
		int    v[11];
		stim_t s;
		ok    = 1'b0;
		total = 0;
		fd    = $fopen("bench/pong_stim.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				code = $fgets(line, fd);
				if (code > 0 && line[0] != "#") // skip header comments
				begin
					n = $sscanf(line, "%d %h %h %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
						v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
					if (n == 11)
					begin
						s.rounds    = 16'(v[0]);
						s.cmd_l     = 3'(v[1]);
						s.cmd_r     = 3'(v[2]);
						s.pulse     = 2'(v[3]);
						s.pad_l_y   = 8'(v[4]);
						s.pad_r_y   = 8'(v[5]);
						s.ball_x    = 9'(v[6]);
						s.ball_y    = 8'(v[7]);
						s.score_l   = 4'(v[8]);
						s.score_r   = 4'(v[9]);
						s.game_over = 1'(v[10]);
						steps.push_back(s);
						total += v[0];
					end
				end
			end
			$fclose(fd);
			ok = (steps.size() > 0);
		end
	endtask

	// drive one row, wait its rounds out, then hand the expectations over
	task automatic run_step(input int idx);
		stim_t s;
		int    target;
		s = steps[idx];
		@(negedge clk);
		target = rounds_done + int'(s.rounds);
		@(posedge clk);
		cmd_l    <= s.cmd_l;
		cmd_r    <= s.cmd_r;
		serve    <= (s.pulse == 2'd1);
		new_game <= (s.pulse == 2'd2);
		@(posedge clk);
		serve    <= 1'b0; // single cycle pulses
		new_game <= 1'b0;
		while (rounds_done < target)
			@(negedge clk);
		@(posedge clk);
		check_req     <= 1'b1;
		step_num      <= idx + 1;
		exp_ball      <= '{x: s.ball_x, y: s.ball_y};
		exp_pad[0]    <= '{x: 9'(`PONG_PADDLE_X_L), y: s.pad_l_y};
		exp_pad[1]    <= '{x: 9'(`PONG_PADDLE_X_R), y: s.pad_r_y};
		exp_score_l   <= s.score_l;
		exp_score_r   <= s.score_r;
		exp_game_over <= s.game_over;
		@(posedge clk);
		check_req <= 1'b0;
	endtask

	initial
	begin
		bit ok;
		int total;
		reset         <= 1'b1;
		cmd_l         <= '0;
		cmd_r         <= '0;
		serve         <= 1'b0;
		new_game      <= 1'b0;
		check_req     <= 1'b0;
		step_num      <= 0;
		exp_ball      <= '0;
		exp_pad       <= '0;
		exp_score_l   <= 4'd0;
		exp_score_r   <= 4'd0;
		exp_game_over <= 1'b0;
		load_stim(ok, total);
		if (!ok)
		begin
			$display("stimulus file missing or empty");
			$display("TEST FAILED");
			$finish;
		end
		else
		begin
			// worst case one full round per counted round, plus per step slack
			watchdog_cycles = total * (102 + `PONG_FRAME_CYCLES) + steps.size() * 20 + 500;
			repeat (3) @(posedge clk);
			reset <= 1'b0;
			repeat (5) @(posedge clk); // idle, nothing may be plotted yet
			foreach (steps[i])
				run_step(i);
			repeat (2) @(posedge clk);
			@(negedge clk);
			$display("%0d steps run, %0d failed, %0d mismatches", steps.size(), steps_failed,
				errors);
			if (errors == 0 && steps_failed == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

	// watchdog
	initial
	begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, a step never completed", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/pong_stim.txt
# rounds cmd_l cmd_r pulse(0 none, 1 serve, 2 new game) pad_l_y pad_r_y ball_x ball_y score_l score_r game_over
# cmd columns hex with bits up go speed, all other columns decimal
1 0 0 2 116 116 154 118 0 0 0
3 6 3 0 113 122 148 124 0 0 0
2 0 7 0 113 118 144 128 0 0 0
40 3 7 0 193 38 64 208 0 0 0
13 2 0 0 206 38 38 234 0 0 0
17 0 7 0 206 4 8 204 0 0 0
4 0 7 0 206 0 16 196 0 0 0
10 3 0 0 216 0 36 176 0 0 0
141 0 0 0 116 116 156 116 1 0 0
1 0 0 1 116 116 154 118 1 0 0
78 0 0 0 116 116 156 116 1 1 0
79 0 0 1 116 116 156 116 1 2 0
79 0 0 1 116 116 156 116 1 3 0
79 0 0 1 116 116 156 116 1 4 0
79 0 0 1 116 116 156 116 1 5 0
79 0 0 1 116 116 156 116 1 6 0
79 0 0 1 116 116 156 116 1 7 0
79 0 0 1 116 116 156 116 1 8 0
79 0 0 1 116 116 156 116 1 9 0
79 0 0 1 116 116 156 116 1 10 0
79 0 0 1 116 116 156 116 1 11 1
1 0 0 2 116 116 154 118 0 0 0

// File: compile.f
+incdir+source
source/pong_pkg.sv
source/round_sequencer.sv
source/ball_engine.sv
source/paddle_unit.sv
source/sprite_plotter.sv
source/pong_top.sv
bench/pong_sva.sv
bench/pong_checker.sv
bench/pong_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the pong testbench with Verilator, passes only if the log holds the pass line
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module pong_tb \
	--Mdir obj_dir -o pong_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/pong_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -q "^TEST OK$" "$LOG"; then
	exit 0
else
	echo "pass line not found in $LOG"
	exit 1
fi
